// File: source/cu_pkg.sv
`default_nettype none

package cu_pkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int OPCODE_BITS      = 4;
    localparam int OFFMEM_ADDR_BITS = 32;
    localparam int UB_ADDR_BITS     = 8;
    localparam int WB_ADDR_BITS     = 8;
    localparam int ACC_ADDR_BITS    = 6;

    // Buffer lines are 16 bytes wide
    localparam int ADDR_LSB = 4;

    ////////////////////
    // Encodings
    ////////////////////

    typedef enum logic [OPCODE_BITS-1:0] {
        op_idle              = 4'h0,
        op_data_fifo         = 4'h1,
        op_weight_fifo       = 4'h2,
        op_axi_to_ub         = 4'h3,
        op_axi_to_wb         = 4'h4,
        op_ub_to_data_fifo   = 4'h5,
        op_ub_to_weight_fifo = 4'h6,
        op_mat_mul           = 4'h7,
        op_mat_mul_acc       = 4'h8,
        op_acc_to_ub         = 4'h9,
        // Store code, no longer executed
        op_ub_to_axi         = 4'ha
    } opcode_t;

    typedef enum logic [2:0] {
        cls_idle,
        cls_single,
        cls_double,
        cls_load,
        cls_unknown
    } inst_class_t;

    typedef enum logic [1:0] {
        axi_idle = 2'd0,
        axi_load = 2'd1
    } axi_mode_t;

    ////////////////////
    // Bundles
    ////////////////////

    // Destination in addra, source in addrb
    typedef struct packed {
        opcode_t                     opcode;
        logic [OFFMEM_ADDR_BITS-1:0] addra;
        logic [OFFMEM_ADDR_BITS-1:0] addrb;
    } inst_t;

    typedef struct packed {
        logic                     read_ub;
        logic                     write_ub;
        logic                     read_wb;
        logic                     write_wb;
        logic                     read_acc;
        logic                     write_acc;
        logic [UB_ADDR_BITS-1:0]  ub_addra;
        logic [UB_ADDR_BITS-1:0]  ub_addrb;
        logic [WB_ADDR_BITS-1:0]  wb_addra;
        logic [WB_ADDR_BITS-1:0]  wb_addrb;
        logic [ACC_ADDR_BITS-1:0] acc_addra;
        logic [ACC_ADDR_BITS-1:0] acc_addrb;
    } buf_ctrl_t;

    typedef struct packed {
        logic data_fifo_en;
        logic weight_fifo_en;
        logic mmu_load_weight_en;
        logic mm_en;
        logic acc_en;
    } array_ctrl_t;

    typedef struct packed {
        axi_mode_t                   mode;
        logic                        init_txn_pulse;
        logic [OFFMEM_ADDR_BITS-1:0] offmem_addrb;
    } axi_req_t;

endpackage

`default_nettype wire

// File: source/inst_capture.sv
`default_nettype none

module inst_capture (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                init_inst_pulse,
    input  cu_pkg::inst_t       instruction,
    output cu_pkg::inst_t       inst,
    output cu_pkg::inst_class_t inst_class,
    output logic                start
);

    logic                                    level_q;
    cu_pkg::opcode_t                         opcode_q;
    logic [cu_pkg::OFFMEM_ADDR_BITS-1:0]     addra_q;
    logic [cu_pkg::OFFMEM_ADDR_BITS-1:0]     addrb_q;
    cu_pkg::inst_class_t                     next_class;

    // Rising edge of the start level
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            level_q <= 1'b0;
        end else begin
            level_q <= init_inst_pulse;
        end
    end

    assign start = init_inst_pulse & ~level_q;

    ////////////////////
    // Opcode classes
    ////////////////////

    always_comb begin
        case (instruction.opcode)
            cu_pkg::op_idle: next_class = cu_pkg::cls_idle;
            cu_pkg::op_data_fifo,
            cu_pkg::op_weight_fifo,
            cu_pkg::op_ub_to_data_fifo,
            cu_pkg::op_ub_to_weight_fifo: next_class = cu_pkg::cls_single;
            cu_pkg::op_mat_mul,
            cu_pkg::op_mat_mul_acc,
            cu_pkg::op_acc_to_ub: next_class = cu_pkg::cls_double;
            cu_pkg::op_axi_to_ub,
            cu_pkg::op_axi_to_wb: next_class = cu_pkg::cls_load;
            // Store code and undefined codes
            default: next_class = cu_pkg::cls_unknown;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            opcode_q   <= cu_pkg::op_idle;
            inst_class <= cu_pkg::cls_idle;
        end else if (start) begin
            opcode_q   <= instruction.opcode;
            inst_class <= next_class;
        end
    end

    // Off-chip addresses
    always_ff @(posedge clk) begin
        if (start) begin
            addra_q <= instruction.addra;
            addrb_q <= instruction.addrb;
        end
    end

    assign inst = '{opcode: opcode_q, addra: addra_q, addrb: addrb_q};

    // A held start level must not retrigger
    assert property (@(posedge clk) disable iff (!reset_n) start |=> !start)
        else $error("start pulse lasted more than one cycle");

endmodule

`default_nettype wire

// File: source/step_sequencer.sv
`default_nettype none

module step_sequencer (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                start,
    input  cu_pkg::inst_class_t inst_class,
    input  logic                load_end,
    output logic [1:0]          step,
    output logic                done,
    output logic                idle_flag
);

    ////////////////////
    // Phase and done
    ////////////////////

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            step <= 2'd0;
            done <= 1'b0;
        end else if (start) begin
            // New instruction replaces whatever is running
            step <= 2'd0;
            done <= 1'b0;
        end else if (!done) begin
            case (inst_class)
                cu_pkg::cls_idle,
                cu_pkg::cls_single: begin
                    done <= 1'b1;
                end
                cu_pkg::cls_double: begin
                    if (step == 2'd0) begin
                        step <= 2'd1;
                    end else begin
                        done <= 1'b1;
                    end
                end
                cu_pkg::cls_load: begin
                    // Phase 0 issues the request, phase 1 waits for data
                    if (load_end) begin
                        done <= 1'b1;
                    end else if (step == 2'd0) begin
                        step <= 2'd1;
                    end
                end
                default: begin
                    // Unknown opcode parks here until the next start
                    step <= step;
                end
            endcase
        end
    end

    assign idle_flag = (inst_class == cu_pkg::cls_idle) || done;

    ////////////////////
    // Checks
    ////////////////////

    // Completion holds until another instruction arrives
    assert property (@(posedge clk) disable iff (!reset_n) $fell(done) |-> $past(start))
        else $error("done cleared without a new instruction");

    assert property (@(posedge clk) disable iff (!reset_n)
                     inst_class != cu_pkg::cls_load |-> step <= 2'd1)
        else $error("phase beyond 1 for a fixed-length instruction");

endmodule

`default_nettype wire

// File: source/ctrl_decode.sv
`default_nettype none

module ctrl_decode #(
    parameter int DATA_BITS = 128
) (
    input  cu_pkg::inst_t       inst,
    input  cu_pkg::inst_class_t inst_class,
    input  logic [1:0]          step,
    input  logic                done,
    input  logic                txn_done,
    input  logic [DATA_BITS-1:0] din,
    input  logic [DATA_BITS-1:0] rin,
    output cu_pkg::buf_ctrl_t   buf_ctrl,
    output cu_pkg::array_ctrl_t array_ctrl,
    output cu_pkg::axi_req_t    axi_req,
    output logic [DATA_BITS-1:0] dout,
    output logic                load_end
);

    logic [cu_pkg::UB_ADDR_BITS-1:0]  ub_dst;
    logic [cu_pkg::UB_ADDR_BITS-1:0]  ub_src;
    logic [cu_pkg::WB_ADDR_BITS-1:0]  wb_dst;
    logic [cu_pkg::WB_ADDR_BITS-1:0]  wb_src;
    logic [cu_pkg::ACC_ADDR_BITS-1:0] acc_dst;
    logic [cu_pkg::ACC_ADDR_BITS-1:0] acc_src;

    // Buffer line addresses out of the byte addresses
    assign ub_dst  = inst.addra[cu_pkg::ADDR_LSB +: cu_pkg::UB_ADDR_BITS];
    assign ub_src  = inst.addrb[cu_pkg::ADDR_LSB +: cu_pkg::UB_ADDR_BITS];
    assign wb_dst  = inst.addra[cu_pkg::ADDR_LSB +: cu_pkg::WB_ADDR_BITS];
    assign wb_src  = inst.addrb[cu_pkg::ADDR_LSB +: cu_pkg::WB_ADDR_BITS];
    assign acc_dst = inst.addra[cu_pkg::ADDR_LSB +: cu_pkg::ACC_ADDR_BITS];
    assign acc_src = inst.addrb[cu_pkg::ADDR_LSB +: cu_pkg::ACC_ADDR_BITS];

    // Data from the AXI side has arrived
    assign load_end = !done && (inst_class == cu_pkg::cls_load) && txn_done;

    ////////////////////
    // Output table
    ////////////////////

    always_comb begin
        buf_ctrl   = '0;
        array_ctrl = '0;
        axi_req    = '0;
        dout       = '0;

        if (!done) begin
            case (inst.opcode)
                cu_pkg::op_data_fifo: begin
                    array_ctrl.data_fifo_en = 1'b1;
                end
                cu_pkg::op_weight_fifo: begin
                    array_ctrl.weight_fifo_en = 1'b1;
                end
                cu_pkg::op_axi_to_ub,
                cu_pkg::op_axi_to_wb: begin
                    if (inst.opcode == cu_pkg::op_axi_to_ub) begin
                        buf_ctrl.ub_addra = ub_dst;
                    end
                    if (load_end) begin
                        axi_req.mode = cu_pkg::axi_idle;
                        dout         = din;
                        if (inst.opcode == cu_pkg::op_axi_to_ub) begin
                            buf_ctrl.write_ub    = 1'b1;
                            axi_req.offmem_addrb = inst.addrb;
                        end else begin
                            buf_ctrl.write_wb = 1'b1;
                            buf_ctrl.wb_addra = wb_dst;
                        end
                    end else begin
                        // Request goes out once, then hold the mode
                        axi_req.mode           = cu_pkg::axi_load;
                        axi_req.init_txn_pulse = (step == 2'd0);
                        axi_req.offmem_addrb   = inst.addrb;
                    end
                end
                cu_pkg::op_ub_to_data_fifo: begin
                    buf_ctrl.read_ub        = 1'b1;
                    buf_ctrl.ub_addrb       = ub_src;
                    array_ctrl.data_fifo_en = 1'b1;
                end
                cu_pkg::op_ub_to_weight_fifo: begin
                    buf_ctrl.read_wb              = 1'b1;
                    buf_ctrl.wb_addrb             = wb_src;
                    array_ctrl.mmu_load_weight_en = 1'b1;
                    array_ctrl.weight_fifo_en     = 1'b1;
                end
                cu_pkg::op_mat_mul,
                cu_pkg::op_mat_mul_acc: begin
                    array_ctrl.acc_en = (inst.opcode == cu_pkg::op_mat_mul_acc);
                    if (step == 2'd0) begin
                        buf_ctrl.read_ub  = 1'b1;
                        buf_ctrl.ub_addrb = ub_src;
                    end else begin
                        buf_ctrl.write_acc      = 1'b1;
                        buf_ctrl.acc_addra      = acc_dst;
                        array_ctrl.data_fifo_en = 1'b1;
                        array_ctrl.mm_en        = 1'b1;
                    end
                end
                cu_pkg::op_acc_to_ub: begin
                    if (step == 2'd0) begin
                        buf_ctrl.read_acc  = 1'b1;
                        buf_ctrl.acc_addrb = acc_src;
                    end else begin
                        buf_ctrl.write_ub = 1'b1;
                        buf_ctrl.ub_addra = ub_dst;
                        dout              = rin;
                    end
                end
                default: begin
                    // Idle, store code and undefined codes drive nothing
                    dout = '0;
                end
            endcase
        end
    end

    // UB has one port per direction, never both in a cycle
    always_comb begin
        assert (!(buf_ctrl.read_ub && buf_ctrl.write_ub))
            else $error("UB read and write strobes both high");
    end

endmodule

`default_nettype wire

// File: source/control_unit.sv
`default_nettype none

module control_unit #(
    parameter int DATA_BITS = 128
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  cu_pkg::inst_t        instruction,
    input  logic                 init_inst_pulse,
    input  logic                 txn_done,
    input  logic [DATA_BITS-1:0] din,
    input  logic [DATA_BITS-1:0] rin,
    output cu_pkg::buf_ctrl_t    buf_ctrl,
    output cu_pkg::array_ctrl_t  array_ctrl,
    output cu_pkg::axi_req_t     axi_req,
    output logic [DATA_BITS-1:0] dout,
    output logic                 flag,
    output logic                 idle_flag
);

    cu_pkg::inst_t       inst;
    cu_pkg::inst_class_t inst_class;
    logic                start;
    logic [1:0]          step;
    logic                load_end;

    ////////////////////
    // Capture
    ////////////////////

    inst_capture i_capture (
        .clk             (clk),
        .reset_n         (reset_n),
        .init_inst_pulse (init_inst_pulse),
        .instruction     (instruction),
        .inst            (inst),
        .inst_class      (inst_class),
        .start           (start)
    );

    ////////////////////
    // Sequencing
    ////////////////////

    step_sequencer i_sequencer (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (start),
        .inst_class (inst_class),
        .load_end   (load_end),
        .step       (step),
        .done       (flag),
        .idle_flag  (idle_flag)
    );

    ////////////////////
    // Decode
    ////////////////////

    ctrl_decode #(
        .DATA_BITS (DATA_BITS)
    ) i_decode (
        .inst       (inst),
        .inst_class (inst_class),
        .step       (step),
        .done       (flag),
        .txn_done   (txn_done),
        .din        (din),
        .rin        (rin),
        .buf_ctrl   (buf_ctrl),
        .array_ctrl (array_ctrl),
        .axi_req    (axi_req),
        .dout       (dout),
        .load_end   (load_end)
    );

endmodule

`default_nettype wire

// File: testbench/tb_control_unit.sv
`default_nettype none

module tb_control_unit;

    localparam int DATA_BITS     = 128;
    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 1;
    localparam int MAX_WAIT      = 6;
    localparam int NUM_INSTS     = 24;
    localparam int WATCHDOG_TIME = NUM_INSTS * (10 + MAX_WAIT) * CLK_PERIOD;

    logic                 clk;
    logic                 reset_n;
    cu_pkg::inst_t        instruction;
    logic                 init_inst_pulse;
    logic                 txn_done;
    logic [DATA_BITS-1:0] din;
    logic [DATA_BITS-1:0] rin;
    cu_pkg::buf_ctrl_t    buf_ctrl;
    cu_pkg::array_ctrl_t  array_ctrl;
    cu_pkg::axi_req_t     axi_req;
    logic [DATA_BITS-1:0] dout;
    logic                 flag;
    logic                 idle_flag;

    // Expected outputs for the cycle in progress
    cu_pkg::buf_ctrl_t    exp_buf;
    cu_pkg::array_ctrl_t  exp_arr;
    cu_pkg::axi_req_t     exp_axi;
    logic [DATA_BITS-1:0] exp_dout;
    logic                 exp_flag;
    logic                 exp_idle;

    integer seed = 85;
    string  test_name = "reset";

    control_unit #(
        .DATA_BITS (DATA_BITS)
    ) i_dut (
        .clk             (clk),
        .reset_n         (reset_n),
        .instruction     (instruction),
        .init_inst_pulse (init_inst_pulse),
        .txn_done        (txn_done),
        .din             (din),
        .rin             (rin),
        .buf_ctrl        (buf_ctrl),
        .array_ctrl      (array_ctrl),
        .axi_req         (axi_req),
        .dout            (dout),
        .flag            (flag),
        .idle_flag       (idle_flag)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout at %0t, the instruction sequence never completed", $time);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(input string what, input logic [DATA_BITS-1:0] expected,
                                   input logic [DATA_BITS-1:0] actual);
        $display("ERR %s %s expected %0h actual %0h", test_name, what, expected, actual);
        $display("Test failures found");
        $fatal(1, "output check failed");
    endtask

    ////////////////////
    // Output checks
    ////////////////////

    // Checked mid-cycle, where inputs and outputs have settled
    assert property (@(negedge clk) disable iff (!reset_n) flag == exp_flag)
        else report_mismatch("flag", DATA_BITS'(exp_flag), DATA_BITS'(flag));
    assert property (@(negedge clk) disable iff (!reset_n) idle_flag == exp_idle)
        else report_mismatch("idle_flag", DATA_BITS'(exp_idle), DATA_BITS'(idle_flag));
    assert property (@(negedge clk) disable iff (!reset_n) buf_ctrl == exp_buf)
        else report_mismatch("buf_ctrl", DATA_BITS'(exp_buf), DATA_BITS'(buf_ctrl));
    assert property (@(negedge clk) disable iff (!reset_n) array_ctrl == exp_arr)
        else report_mismatch("array_ctrl", DATA_BITS'(exp_arr), DATA_BITS'(array_ctrl));
    assert property (@(negedge clk) disable iff (!reset_n) axi_req == exp_axi)
        else report_mismatch("axi_req", DATA_BITS'(exp_axi), DATA_BITS'(axi_req));
    assert property (@(negedge clk) disable iff (!reset_n) dout == exp_dout)
        else report_mismatch("dout", exp_dout, dout);

    ////////////////////
    // Model helpers
    ////////////////////

    // Line addresses start at byte bit 4
    function automatic logic [7:0] ub_line(input logic [31:0] addr);
        return addr[11:4];
    endfunction

    function automatic logic [7:0] wb_line(input logic [31:0] addr);
        return addr[11:4];
    endfunction

    function automatic logic [5:0] acc_line(input logic [31:0] addr);
        return addr[9:4];
    endfunction

    task automatic clear_expect();
        exp_buf  = '0;
        exp_arr  = '0;
        exp_axi  = '0;
        exp_dout = '0;
        exp_flag = 1'b0;
        exp_idle = 1'b0;
    endtask

    task automatic expect_done();
        clear_expect();
        exp_flag = 1'b1;
        exp_idle = 1'b1;
    endtask

    // Next cycle, with fresh data on both data inputs
    task automatic tick();
        @(posedge clk);
        #(DRIVE_DELAY);
        din = {$random(seed), $random(seed), $random(seed), $random(seed)};
        rin = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    task automatic finish_inst();
        tick();
        expect_done();
    endtask

    // Returns in the first cycle after the capture edge
    task automatic launch(input cu_pkg::opcode_t op, input logic [31:0] a,
                          input logic [31:0] b);
        tick();
        instruction     = '{opcode: op, addra: a, addrb: b};
        init_inst_pulse = 1'b1;
        tick();
        init_inst_pulse = 1'b0;
        clear_expect();
    endtask

    ////////////////////
    // Instruction runs
    ////////////////////

    task automatic run_single(input cu_pkg::opcode_t op);
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = $random(seed);
        launch(op, a, b);
        case (op)
            cu_pkg::op_idle: exp_idle = 1'b1;
            cu_pkg::op_data_fifo: exp_arr.data_fifo_en = 1'b1;
            cu_pkg::op_weight_fifo: exp_arr.weight_fifo_en = 1'b1;
            cu_pkg::op_ub_to_data_fifo: begin
                exp_buf.read_ub      = 1'b1;
                exp_buf.ub_addrb     = ub_line(b);
                exp_arr.data_fifo_en = 1'b1;
            end
            cu_pkg::op_ub_to_weight_fifo: begin
                exp_buf.read_wb            = 1'b1;
                exp_buf.wb_addrb           = wb_line(b);
                exp_arr.mmu_load_weight_en = 1'b1;
                exp_arr.weight_fifo_en     = 1'b1;
            end
            default: ;
        endcase
        finish_inst();
    endtask

    task automatic run_double(input cu_pkg::opcode_t op);
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = $random(seed);
        launch(op, a, b);
        if (op == cu_pkg::op_acc_to_ub) begin
            exp_buf.read_acc  = 1'b1;
            exp_buf.acc_addrb = acc_line(b);
        end else begin
            exp_buf.read_ub  = 1'b1;
            exp_buf.ub_addrb = ub_line(b);
            exp_arr.acc_en   = (op == cu_pkg::op_mat_mul_acc);
        end
        tick();
        clear_expect();
        if (op == cu_pkg::op_acc_to_ub) begin
            exp_buf.write_ub = 1'b1;
            exp_buf.ub_addra = ub_line(a);
            exp_dout         = rin;
        end else begin
            exp_buf.write_acc    = 1'b1;
            exp_buf.acc_addra    = acc_line(a);
            exp_arr.data_fifo_en = 1'b1;
            exp_arr.mm_en        = 1'b1;
            exp_arr.acc_en       = (op == cu_pkg::op_mat_mul_acc);
        end
        finish_inst();
    endtask

    task automatic run_load(input cu_pkg::opcode_t op, input int wait_len);
        logic [31:0] a;
        logic [31:0] b;
        int          i;
        a = $random(seed);
        b = $random(seed);
        launch(op, a, b);
        for (i = 0; i < wait_len; i++) begin
            if (i > 0) begin
                tick();
                clear_expect();
            end
            exp_axi.mode           = cu_pkg::axi_load;
            exp_axi.init_txn_pulse = (i == 0);
            exp_axi.offmem_addrb   = b;
            if (op == cu_pkg::op_axi_to_ub) begin
                exp_buf.ub_addra = ub_line(a);
            end
        end
        if (wait_len > 0) begin
            tick();
            clear_expect();
        end
        // Data arrives this cycle
        txn_done     = 1'b1;
        exp_axi.mode = cu_pkg::axi_idle;
        exp_dout     = din;
        if (op == cu_pkg::op_axi_to_ub) begin
            exp_buf.write_ub     = 1'b1;
            exp_buf.ub_addra     = ub_line(a);
            exp_axi.offmem_addrb = b;
        end else begin
            exp_buf.write_wb = 1'b1;
            exp_buf.wb_addra = wb_line(a);
        end
        finish_inst();
        txn_done = 1'b0;
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        int round;
        int wait_len;
        reset_n         = 1'b0;
        instruction     = '0;
        init_inst_pulse = 1'b0;
        txn_done        = 1'b0;
        din             = '0;
        rin             = '0;
        clear_expect();
        exp_idle = 1'b1;
        repeat (2) @(posedge clk);
        #(DRIVE_DELAY);
        reset_n = 1'b1;
        // Idle opcode from reset completes one edge later
        tick();
        expect_done();
        tick();

        test_name = "single_phase";
        run_single(cu_pkg::op_data_fifo);
        run_single(cu_pkg::op_weight_fifo);
        run_single(cu_pkg::op_ub_to_data_fifo);
        run_single(cu_pkg::op_ub_to_weight_fifo);
        run_single(cu_pkg::op_idle);

        test_name = "double_phase";
        for (round = 0; round < 2; round++) begin
            run_double(cu_pkg::op_mat_mul);
            run_double(cu_pkg::op_mat_mul_acc);
            run_double(cu_pkg::op_acc_to_ub);
        end

        test_name = "axi_load";
        for (round = 0; round < 4; round++) begin
            wait_len = (round == 0) ? 0 : int'($unsigned($random(seed)) % (MAX_WAIT + 1));
            run_load(cu_pkg::op_axi_to_ub, wait_len);
            wait_len = (round == 0) ? 0 : int'($unsigned($random(seed)) % (MAX_WAIT + 1));
            run_load(cu_pkg::op_axi_to_wb, wait_len);
        end

        test_name = "held_start";
        tick();
        instruction     = '{opcode: cu_pkg::op_weight_fifo, addra: '0, addrb: '0};
        init_inst_pulse = 1'b1;
        tick();
        clear_expect();
        exp_arr.weight_fifo_en = 1'b1;
        tick();
        expect_done();
        repeat (3) tick();
        init_inst_pulse = 1'b0;
        tick();

        test_name = "unknown_opcode";
        launch(cu_pkg::op_ub_to_axi, $random(seed), $random(seed));
        repeat (4) tick();
        launch(cu_pkg::opcode_t'(4'hf), $random(seed), $random(seed));
        repeat (4) tick();
        // A new instruction takes over from the parked one
        run_single(cu_pkg::op_data_fifo);
        tick();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
source/cu_pkg.sv
source/inst_capture.sv
source/step_sequencer.sv
source/ctrl_decode.sv
source/control_unit.sv
testbench/tb_control_unit.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_control_unit
FILELIST := build.f
PASS     := All tests passed!

SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS)"

clean:
	rm -rf obj_dir
